/* common/isaPkg.sv */
`default_nettype none

package isaPkg;

    // major opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // function field of OP_SPECIAL
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    // one instruction word, two field layouts
    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } rView;
        struct packed {
            logic [5:0]  op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } iView;
    } instWord_u;

endpackage

`default_nettype wire

/* common/pipePkg.sv */
`default_nettype none

package pipePkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'hbfc0_0000; // boot vector

    localparam int QUEUE_DEPTH = 4;
    localparam int QCNT_W      = 3; // holds 0..QUEUE_DEPTH

    // micro-ops from decode to execute
    localparam int ALUOP_W = 4;
    localparam logic [ALUOP_W-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALUOP_W-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALUOP_W-1:0] ALU_AND  = 4'd2;
    localparam logic [ALUOP_W-1:0] ALU_OR   = 4'd3;
    localparam logic [ALUOP_W-1:0] ALU_XOR  = 4'd4;
    localparam logic [ALUOP_W-1:0] ALU_NOR  = 4'd5;
    localparam logic [ALUOP_W-1:0] ALU_SLT  = 4'd6;
    localparam logic [ALUOP_W-1:0] ALU_SLTU = 4'd7;
    localparam logic [ALUOP_W-1:0] ALU_SLL  = 4'd8;
    localparam logic [ALUOP_W-1:0] ALU_SRL  = 4'd9;
    localparam logic [ALUOP_W-1:0] ALU_LUI  = 4'd10;

    // operand source in decode
    localparam logic [1:0] FWD_REG = 2'd0;
    localparam logic [1:0] FWD_E   = 2'd1;
    localparam logic [1:0] FWD_W   = 2'd2;

endpackage

`default_nettype wire

/* fetch/fetchUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchUnit (
    input  logic                          clk,
    input  logic                          rstN_i,
    input  logic                          iCacheStall_i,
    input  logic [pipePkg::XLEN-1:0]      inst_i,
    input  logic [pipePkg::QCNT_W-1:0]    qLevel_i,
    output logic [pipePkg::XLEN-1:0]      pcF_o,
    output logic                          instEn_o,
    output logic                          push_o,
    output logic [pipePkg::XLEN-1:0]      pushPc_o,
    output isaPkg::instWord_u             pushInst_o
);
    import pipePkg::*;

    logic              fetchOn;  // low for the first cycle out of reset
    logic              validF2;  // request in flight
    logic [XLEN-1:0]   pcF2;
    logic [QCNT_W-1:0] used;

    // queue entries plus the one still coming back from memory
    assign used = qLevel_i + QCNT_W'(validF2);

    // new request only if it is sure to find a free slot
    assign instEn_o = fetchOn & ~iCacheStall_i & (used < QCNT_W'(QUEUE_DEPTH));

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            pcF_o   <= RESET_PC;
            validF2 <= 1'b0;
            fetchOn <= 1'b0;
        end else begin
            fetchOn <= 1'b1;
            if (!iCacheStall_i) begin  // both stages hold on a cache stall
                validF2 <= instEn_o;
                if (instEn_o) begin
                    pcF_o <= pcF_o + XLEN'(4);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!iCacheStall_i && instEn_o) begin
            pcF2 <= pcF_o;
        end
    end

    // returned word is valid in the first unstalled cycle
    assign push_o     = validF2 & ~iCacheStall_i;
    assign pushPc_o   = pcF2;
    assign pushInst_o = inst_i;

endmodule

`default_nettype wire

/* fetch/instQueue.sv */
`timescale 1ns/1ps
`default_nettype none

module instQueue (
    input  logic                          clk,
    input  logic                          rstN_i,
    input  logic                          push_i,
    input  logic [pipePkg::XLEN-1:0]      pushPc_i,
    input  isaPkg::instWord_u             pushInst_i,
    input  logic                          pop_i,
    output logic [pipePkg::QCNT_W-1:0]    level_o,
    output logic                          empty_o,
    output logic [pipePkg::XLEN-1:0]      headPc_o,
    output isaPkg::instWord_u             headInst_o
);
    import pipePkg::*;
    import isaPkg::*;

    logic [XLEN-1:0] pcMem   [QUEUE_DEPTH];
    instWord_u       instMem [QUEUE_DEPTH];

    logic [$clog2(QUEUE_DEPTH)-1:0] rdPtr;
    logic [$clog2(QUEUE_DEPTH)-1:0] wrPtr;
    logic [QCNT_W-1:0]              count;

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (push_i) begin
                wrPtr <= wrPtr + 1'b1;  // wraps at depth
            end
            if (pop_i) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count <= count + QCNT_W'(push_i) - QCNT_W'(pop_i);
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            pcMem[wrPtr]   <= pushPc_i;
            instMem[wrPtr] <= pushInst_i;
        end
    end

    assign level_o    = count;
    assign empty_o    = (count == '0);
    assign headPc_o   = pcMem[rdPtr];
    assign headInst_o = instMem[rdPtr];

endmodule

`default_nettype wire

/* core/decodeUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeUnit (
    input  logic                          dCacheStall_i,
    input  logic                          empty_i,
    input  logic [pipePkg::XLEN-1:0]      headPc_i,
    input  isaPkg::instWord_u             headInst_i,
    input  logic [pipePkg::XLEN-1:0]      rdata1_i,
    input  logic [pipePkg::XLEN-1:0]      rdata2_i,
    input  logic                          regWriteE_i,
    input  logic [pipePkg::REG_AW-1:0]    writeRegE_i,
    input  logic [pipePkg::XLEN-1:0]      resultE_i,
    input  logic                          regWriteW_i,
    input  logic [pipePkg::REG_AW-1:0]    writeRegW_i,
    input  logic [pipePkg::XLEN-1:0]      resultW_i,
    output logic                          pop_o,
    output logic [pipePkg::REG_AW-1:0]    raddr1_o,
    output logic [pipePkg::REG_AW-1:0]    raddr2_o,
    output logic                          validD_o,
    output logic [pipePkg::ALUOP_W-1:0]   aluOpD_o,
    output logic [pipePkg::XLEN-1:0]      srcAD_o,
    output logic [pipePkg::XLEN-1:0]      srcBD_o,
    output logic [pipePkg::REG_AW-1:0]    shamtD_o,
    output logic                          regWriteD_o,
    output logic [pipePkg::REG_AW-1:0]    writeRegD_o,
    output logic [pipePkg::XLEN-1:0]      pcD_o
);
    import pipePkg::*;
    import isaPkg::*;

    logic               known;    // encoding is one of the kept set
    logic               isImm;    // srcB from immediate, dest is rt
    logic               signExt;
    logic [XLEN-1:0]    immExt;
    logic [REG_AW-1:0]  dest;
    logic [1:0]         fwdA;
    logic [1:0]         fwdB;
    logic [XLEN-1:0]    opA;
    logic [XLEN-1:0]    opB;

    // youngest producer wins, reg 0 never has a writer
    function automatic logic [1:0] fwdSel(input logic [REG_AW-1:0] addr);
        if (regWriteE_i && writeRegE_i == addr) begin
            return FWD_E;
        end else if (regWriteW_i && writeRegW_i == addr) begin
            return FWD_W;
        end
        return FWD_REG;
    endfunction

    function automatic logic [XLEN-1:0] fwdData(input logic [1:0] sel,
                                                input logic [XLEN-1:0] regVal);
        case (sel)
            FWD_E:   return resultE_i;
            FWD_W:   return resultW_i;
            default: return regVal;
        endcase
    endfunction

    always_comb begin
        known    = 1'b1;
        isImm    = 1'b1;
        signExt  = 1'b0;
        aluOpD_o = ALU_ADD;
        case (headInst_i.rView.op)
            OP_SPECIAL: begin
                isImm = 1'b0;
                case (headInst_i.rView.funct)
                    FN_ADDU: aluOpD_o = ALU_ADD;
                    FN_SUBU: aluOpD_o = ALU_SUB;
                    FN_AND:  aluOpD_o = ALU_AND;
                    FN_OR:   aluOpD_o = ALU_OR;
                    FN_XOR:  aluOpD_o = ALU_XOR;
                    FN_NOR:  aluOpD_o = ALU_NOR;
                    FN_SLT:  aluOpD_o = ALU_SLT;
                    FN_SLTU: aluOpD_o = ALU_SLTU;
                    FN_SLL:  aluOpD_o = ALU_SLL;
                    FN_SRL:  aluOpD_o = ALU_SRL;
                    default: known = 1'b0;
                endcase
            end
            OP_ADDIU: signExt = 1'b1;
            OP_SLTI: begin
                signExt  = 1'b1;
                aluOpD_o = ALU_SLT;
            end
            OP_ANDI: aluOpD_o = ALU_AND;
            OP_ORI:  aluOpD_o = ALU_OR;
            OP_XORI: aluOpD_o = ALU_XOR;
            OP_LUI:  aluOpD_o = ALU_LUI;  // shifted up in execute
            default: known = 1'b0;
        endcase
    end

    assign immExt = signExt ? {{(XLEN-16){headInst_i.iView.imm[15]}}, headInst_i.iView.imm}
                            : {{(XLEN-16){1'b0}}, headInst_i.iView.imm};
    assign dest   = isImm ? headInst_i.iView.rt : headInst_i.rView.rd;

    assign raddr1_o = headInst_i.rView.rs;
    assign raddr2_o = headInst_i.rView.rt;

    assign fwdA = fwdSel(raddr1_o);
    assign fwdB = fwdSel(raddr2_o);
    assign opA  = fwdData(fwdA, rdata1_i);
    assign opB  = fwdData(fwdB, rdata2_i);

    assign pop_o       = ~empty_i & ~dCacheStall_i;
    assign validD_o    = ~empty_i;
    assign srcAD_o     = opA;
    assign srcBD_o     = isImm ? immExt : opB;
    assign shamtD_o    = headInst_i.rView.shamt;
    assign regWriteD_o = validD_o & known & (dest != '0);  // unknown or $0 is a bubble
    assign writeRegD_o = dest;
    assign pcD_o       = headPc_i;

endmodule

`default_nettype wire

/* core/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic                          clk,
    input  logic                          rstN_i,
    input  logic                          we_i,
    input  logic [pipePkg::REG_AW-1:0]    waddr_i,
    input  logic [pipePkg::XLEN-1:0]      wdata_i,
    input  logic [pipePkg::REG_AW-1:0]    raddr1_i,
    input  logic [pipePkg::REG_AW-1:0]    raddr2_i,
    output logic [pipePkg::XLEN-1:0]      rdata1_o,
    output logic [pipePkg::XLEN-1:0]      rdata2_o
);
    import pipePkg::*;

    logic [XLEN-1:0] regs [1:31];  // $0 has no storage

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

/* core/execUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module execUnit (
    input  logic                          clk,
    input  logic                          rstN_i,
    input  logic                          dCacheStall_i,
    input  logic                          validD_i,
    input  logic [pipePkg::ALUOP_W-1:0]   aluOpD_i,
    input  logic [pipePkg::XLEN-1:0]      srcAD_i,
    input  logic [pipePkg::XLEN-1:0]      srcBD_i,
    input  logic [pipePkg::REG_AW-1:0]    shamtD_i,
    input  logic                          regWriteD_i,
    input  logic [pipePkg::REG_AW-1:0]    writeRegD_i,
    input  logic [pipePkg::XLEN-1:0]      pcD_i,
    output logic                          regWriteE_o,
    output logic [pipePkg::REG_AW-1:0]    writeRegE_o,
    output logic [pipePkg::XLEN-1:0]      resultE_o,
    output logic                          regWriteW_o,
    output logic [pipePkg::REG_AW-1:0]    writeRegW_o,
    output logic [pipePkg::XLEN-1:0]      resultW_o,
    output logic [pipePkg::XLEN-1:0]      debugWbPc_o,
    output logic [3:0]                    debugWbRfWen_o,
    output logic [pipePkg::REG_AW-1:0]    debugWbRfWnum_o,
    output logic [pipePkg::XLEN-1:0]      debugWbRfWdata_o
);
    import pipePkg::*;

    logic [ALUOP_W-1:0] aluOpE;
    logic [XLEN-1:0]    srcAE;
    logic [XLEN-1:0]    srcBE;
    logic [REG_AW-1:0]  shamtE;
    logic [XLEN-1:0]    pcE;
    logic [XLEN-1:0]    pcW;

    // control bits of E and W, a bubble enters when nothing was popped
    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            regWriteE_o <= 1'b0;
            regWriteW_o <= 1'b0;
        end else if (!dCacheStall_i) begin
            regWriteE_o <= regWriteD_i;
            regWriteW_o <= regWriteE_o;
        end
    end

    // execute payload only follows real instructions
    always_ff @(posedge clk) begin
        if (!dCacheStall_i && validD_i) begin
            aluOpE      <= aluOpD_i;
            srcAE       <= srcAD_i;
            srcBE       <= srcBD_i;
            shamtE      <= shamtD_i;
            writeRegE_o <= writeRegD_i;
            pcE         <= pcD_i;
        end
    end

    always_comb begin
        case (aluOpE)
            ALU_ADD:  resultE_o = srcAE + srcBE;
            ALU_SUB:  resultE_o = srcAE - srcBE;
            ALU_AND:  resultE_o = srcAE & srcBE;
            ALU_OR:   resultE_o = srcAE | srcBE;
            ALU_XOR:  resultE_o = srcAE ^ srcBE;
            ALU_NOR:  resultE_o = ~(srcAE | srcBE);
            ALU_SLT:  resultE_o = {{(XLEN-1){1'b0}}, $signed(srcAE) < $signed(srcBE)};
            ALU_SLTU: resultE_o = {{(XLEN-1){1'b0}}, srcAE < srcBE};
            ALU_SLL:  resultE_o = srcBE << shamtE;  // shifts take rt
            ALU_SRL:  resultE_o = srcBE >> shamtE;
            ALU_LUI:  resultE_o = {srcBE[15:0], 16'b0};
            default:  resultE_o = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!dCacheStall_i) begin
            writeRegW_o <= writeRegE_o;
            resultW_o   <= resultE_o;
            pcW         <= pcE;
        end
    end

    // write only lands while the back end moves
    assign debugWbRfWen_o   = {4{regWriteW_o & ~dCacheStall_i}};
    assign debugWbPc_o      = pcW;
    assign debugWbRfWnum_o  = writeRegW_o;
    assign debugWbRfWdata_o = resultW_o;

endmodule

`default_nettype wire

/* src/mipsCore.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsCore (
    input  logic                          clk,
    input  logic                          rstN_i,
    input  logic                          iCacheStall_i,
    input  logic                          dCacheStall_i,
    input  logic [pipePkg::XLEN-1:0]      inst_i,
    output logic [pipePkg::XLEN-1:0]      pcF_o,
    output logic                          instEn_o,
    output logic [pipePkg::XLEN-1:0]      debugWbPc_o,
    output logic [3:0]                    debugWbRfWen_o,
    output logic [pipePkg::REG_AW-1:0]    debugWbRfWnum_o,
    output logic [pipePkg::XLEN-1:0]      debugWbRfWdata_o
);
    import pipePkg::*;
    import isaPkg::*;

    logic               push;
    logic [XLEN-1:0]    pushPc;
    instWord_u          pushInst;
    logic [QCNT_W-1:0]  qLevel;
    logic               qEmpty;
    logic [XLEN-1:0]    headPc;
    instWord_u          headInst;
    logic               pop;
    logic [REG_AW-1:0]  raddr1;
    logic [REG_AW-1:0]  raddr2;
    logic [XLEN-1:0]    rdata1;
    logic [XLEN-1:0]    rdata2;
    logic               validD;
    logic [ALUOP_W-1:0] aluOpD;
    logic [XLEN-1:0]    srcAD;
    logic [XLEN-1:0]    srcBD;
    logic [REG_AW-1:0]  shamtD;
    logic               regWriteD;
    logic [REG_AW-1:0]  writeRegD;
    logic [XLEN-1:0]    pcD;
    logic               regWriteE;
    logic [REG_AW-1:0]  writeRegE;
    logic [XLEN-1:0]    resultE;
    logic               regWriteW;
    logic [REG_AW-1:0]  writeRegW;
    logic [XLEN-1:0]    resultW;

    fetchUnit u_fetchUnit (
        .clk(clk), .rstN_i(rstN_i), .iCacheStall_i(iCacheStall_i),
        .inst_i(inst_i), .qLevel_i(qLevel),
        .pcF_o(pcF_o), .instEn_o(instEn_o),
        .push_o(push), .pushPc_o(pushPc), .pushInst_o(pushInst)
    );

    instQueue u_instQueue (
        .clk(clk), .rstN_i(rstN_i),
        .push_i(push), .pushPc_i(pushPc), .pushInst_i(pushInst), .pop_i(pop),
        .level_o(qLevel), .empty_o(qEmpty), .headPc_o(headPc), .headInst_o(headInst)
    );

    decodeUnit u_decodeUnit (
        .dCacheStall_i(dCacheStall_i),
        .empty_i(qEmpty), .headPc_i(headPc), .headInst_i(headInst),
        .rdata1_i(rdata1), .rdata2_i(rdata2),
        .regWriteE_i(regWriteE), .writeRegE_i(writeRegE), .resultE_i(resultE),
        .regWriteW_i(regWriteW), .writeRegW_i(writeRegW), .resultW_i(resultW),
        .pop_o(pop), .raddr1_o(raddr1), .raddr2_o(raddr2),
        .validD_o(validD), .aluOpD_o(aluOpD), .srcAD_o(srcAD), .srcBD_o(srcBD),
        .shamtD_o(shamtD), .regWriteD_o(regWriteD), .writeRegD_o(writeRegD), .pcD_o(pcD)
    );

    // write port shares the debug enable condition
    regFile u_regFile (
        .clk(clk), .rstN_i(rstN_i),
        .we_i(debugWbRfWen_o[0]), .waddr_i(writeRegW), .wdata_i(resultW),
        .raddr1_i(raddr1), .raddr2_i(raddr2),
        .rdata1_o(rdata1), .rdata2_o(rdata2)
    );

    execUnit u_execUnit (
        .clk(clk), .rstN_i(rstN_i), .dCacheStall_i(dCacheStall_i),
        .validD_i(validD), .aluOpD_i(aluOpD), .srcAD_i(srcAD), .srcBD_i(srcBD),
        .shamtD_i(shamtD), .regWriteD_i(regWriteD), .writeRegD_i(writeRegD), .pcD_i(pcD),
        .regWriteE_o(regWriteE), .writeRegE_o(writeRegE), .resultE_o(resultE),
        .regWriteW_o(regWriteW), .writeRegW_o(writeRegW), .resultW_o(resultW),
        .debugWbPc_o(debugWbPc_o), .debugWbRfWen_o(debugWbRfWen_o),
        .debugWbRfWnum_o(debugWbRfWnum_o), .debugWbRfWdata_o(debugWbRfWdata_o)
    );

endmodule

`default_nettype wire

/* verif/tb_mipsCore.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mipsCore;
    import pipePkg::*;

    localparam int MEM_WORDS = 256;

    logic              clk;
    logic              rstN_i;
    logic              iCacheStall_i;
    logic              dCacheStall_i;
    logic [XLEN-1:0]   inst_i;
    logic [XLEN-1:0]   pcF_o;
    logic              instEn_o;
    logic [XLEN-1:0]   debugWbPc_o;
    logic [3:0]        debugWbRfWen_o;
    logic [REG_AW-1:0] debugWbRfWnum_o;
    logic [XLEN-1:0]   debugWbRfWdata_o;

    logic [XLEN-1:0]   imem [MEM_WORDS];
    logic [XLEN-1:0]   expPc [$];
    logic [REG_AW-1:0] expReg [$];
    logic [XLEN-1:0]   expData [$];

    logic [31:0]       lcgState;
    logic [31:0]       rnd;
    logic              iStallNext;
    logic              dStallNext;
    logic [XLEN-1:0]   reqAddr;      // word memory still owes the core
    logic [XLEN-1:0]   nextReq;      // fetch must stay sequential
    int                burstLeft;
    int                burstIssues;  // requests issued inside one dcache stall burst
    int                cycles;
    int                cycleLimit;

    mipsCore u_mipsCore (
        .clk(clk), .rstN_i(rstN_i),
        .iCacheStall_i(iCacheStall_i), .dCacheStall_i(dCacheStall_i), .inst_i(inst_i),
        .pcF_o(pcF_o), .instEn_o(instEn_o),
        .debugWbPc_o(debugWbPc_o), .debugWbRfWen_o(debugWbRfWen_o),
        .debugWbRfWnum_o(debugWbRfWnum_o), .debugWbRfWdata_o(debugWbRfWdata_o)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int wordIndex(input logic [XLEN-1:0] addr);
        logic [XLEN-1:0] off;
        off = (addr - RESET_PC) >> 2;
        return int'(off[7:0]);  // memory wraps at 256 words
    endfunction

    task automatic endWithFailure();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            endWithFailure();
        end
    endtask

    // I lines fill the program memory, W lines queue the expected writes
    task automatic loadTrace();
        int              fd;
        int              n;
        int              idx;
        string           line;
        string           rest;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] c;
        idx = 0;
        fd = $fopen("verif/coreTrace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file verif/coreTrace.txt");
            endWithFailure();
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() >= 2) begin
                    rest = line.substr(1, line.len() - 1);
                    if (line[0] == "I") begin
                        n = $sscanf(rest, "%h", a);
                        imem[idx] = a;
                        idx++;
                    end else if (line[0] == "W") begin
                        n = $sscanf(rest, "%h %h %h", a, b, c);
                        expPc.push_back(a);
                        expReg.push_back(b[REG_AW-1:0]);
                        expData.push_back(c);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        clk           = 1'b0;
        rstN_i        = 1'b0;
        iCacheStall_i = 1'b0;
        dCacheStall_i = 1'b0;
        inst_i        = '0;
        lcgState      = 32'd6;
        reqAddr       = RESET_PC;
        nextReq       = RESET_PC;
        burstLeft     = 0;
        burstIssues   = 0;
        cycles        = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = {6'h3f, 10'h2a5, 8'(i), ~8'(i)};  // unknown opcode, runs as a bubble
        end
        loadTrace();
        cycleLimit = 100 + 40 * expPc.size();
        if (expPc.size() == 0) begin
            $display("the trace file holds no expected writes");
            endWithFailure();
        end
        repeat (9) @(posedge clk);
        @(negedge clk);
        compareValue("pcF_o", pcF_o, RESET_PC);
        compareValue("instEn_o", 32'(instEn_o), 32'h0);
        compareValue("debugWbRfWen_o", 32'(debugWbRfWen_o), 32'h0);
        @(posedge clk);
        rstN_i <= 1'b1;
        while (expPc.size() != 0) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);  // any late write still hits the monitor
        $display("Test passed");
        $finish;
    end

    // memory model, stall generator and writeback monitor
    always @(posedge clk) begin
        if (rstN_i) begin
            cycles++;
            if (cycles > cycleLimit) begin
                $display("timeout after %0d cycles with %0d writes still missing",
                         cycles, expPc.size());
                endWithFailure();
            end
            if (instEn_o && !iCacheStall_i) begin
                compareValue("pcF_o", pcF_o, nextReq);
                nextReq = nextReq + 32'd4;
                reqAddr = pcF_o;
                if (dCacheStall_i) begin
                    burstIssues++;
                end
            end
            if (!dCacheStall_i) begin
                burstIssues = 0;
            end else if (burstIssues > QUEUE_DEPTH) begin
                $display("fetch kept requesting while the queue was full");
                endWithFailure();
            end
            if (debugWbRfWen_o != 4'b0000) begin
                if (expPc.size() == 0) begin
                    $display("register write seen after the last expected write");
                    endWithFailure();
                end else begin
                    compareValue("debugWbRfWen_o", 32'(debugWbRfWen_o), 32'hf);
                    compareValue("debugWbPc_o", debugWbPc_o, expPc.pop_front());
                    compareValue("debugWbRfWnum_o", 32'(debugWbRfWnum_o),
                                 32'(expReg.pop_front()));
                    compareValue("debugWbRfWdata_o", debugWbRfWdata_o, expData.pop_front());
                end
            end
            rnd        = lcgNext(lcgState);
            lcgState   = rnd;
            iStallNext = (rnd[31:30] == 2'b00);
            if (burstLeft > 0) begin
                dStallNext = 1'b1;
                burstLeft--;
            end else if (rnd[29:26] == 4'd0) begin
                dStallNext = 1'b1;
                burstLeft  = 5 + int'(rnd[25:22]);  // long enough to fill the queue
            end else begin
                dStallNext = 1'b0;
            end
            iCacheStall_i <= iStallNext;
            dCacheStall_i <= dStallNext;
            inst_i        <= iStallNext ? {rnd[15:0], rnd[31:16]} : imem[wordIndex(reqAddr)];
        end
    end

endmodule

`default_nettype wire

/* verif/coreTrace.txt */
# I <instruction word> one per word, in order from the reset address
# W <pc> <register> <data> expected register writes, in program order
I 3c011234 lui   $1, 0x1234
I 34215678 ori   $1, $1, 0x5678
I 2402ffff addiu $2, $0, -1
I 00221821 addu  $3, $1, $2
I 00612023 subu  $4, $3, $1
I 00242824 and   $5, $1, $4
I 240600f0 addiu $6, $0, 0xf0
I 00263825 or    $7, $1, $6
I 00e14026 xor   $8, $7, $1
I 01004827 nor   $9, $8, $0
I 0041502a slt   $10, $2, $1
I 0041582b sltu  $11, $2, $1
I 00016100 sll   $12, $1, 4
I 000c6a02 srl   $13, $12, 8
I 284e0000 slti  $14, $2, 0
I 282fffff slti  $15, $1, -1
I 30508001 andi  $16, $2, 0x8001
I 3a11ffff xori  $17, $16, 0xffff
I 8c220000 lw    $2, 0($1) is not kept, no write
I 00210021 addu  $0, $1, $1 writes nothing
I 00009021 addu  $18, $0, $0
I 00220018 mult  $1, $2 is not kept, no write
I 24130005 addiu $19, $0, 5
I 0013a023 subu  $20, $0, $19
I 0293a821 addu  $21, $20, $19
I 3c168000 lui   $22, 0x8000
I 02d5b82a slt   $23, $22, $21
I 0016c7c2 srl   $24, $22, 31
W bfc00000 01 12340000
W bfc00004 01 12345678
W bfc00008 02 ffffffff
W bfc0000c 03 12345677
W bfc00010 04 ffffffff
W bfc00014 05 12345678
W bfc00018 06 000000f0
W bfc0001c 07 123456f8
W bfc00020 08 00000080
W bfc00024 09 ffffff7f
W bfc00028 0a 00000001
W bfc0002c 0b 00000000
W bfc00030 0c 23456780
W bfc00034 0d 00234567
W bfc00038 0e 00000001
W bfc0003c 0f 00000000
W bfc00040 10 00008001
W bfc00044 11 00007ffe
W bfc00050 12 00000000
W bfc00058 13 00000005
W bfc0005c 14 fffffffb
W bfc00060 15 00000000
W bfc00064 16 80000000
W bfc00068 17 00000001
W bfc0006c 18 00000001

/* flist.f */
common/isaPkg.sv
common/pipePkg.sv
fetch/fetchUnit.sv
fetch/instQueue.sv
core/decodeUnit.sv
core/regFile.sv
core/execUnit.sv
src/mipsCore.sv
verif/tb_mipsCore.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -f flist.f \
		--top-module tb_mipsCore -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/Vtb_mipsCore)"; echo "$$out"; \
		echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir
